//--- include/balance_defs.svh
// widths, PID coefficients and torque shaping constants of the balance controller
`ifndef BALANCE_DEFS_SVH
`define BALANCE_DEFS_SVH

//////////////////////////////
// datapath widths
//////////////////////////////
`define BAL_PTCH_W       16   // raw pitch from the inertial unit
`define BAL_ERR_W        10   // pitch error after saturation
`define BAL_DIFF_W       7    // derivative difference after saturation
`define BAL_INTEG_W      18   // integrator accumulator
`define BAL_I_SHIFT      6    // low integrator bits dropped for the I term
`define BAL_TORQUE_W     16   // PID terms and motor torque
`define BAL_LD_W         12   // load cell difference, lft minus rght
`define BAL_STEER_SHIFT  3    // steering uses load difference / 8
`define BAL_SPD_W        11   // unsigned motor speed

//////////////////////////////
// PID coefficients
//////////////////////////////
`define BAL_P_COEFF      14   // proportional gain
`define BAL_D_COEFF      20   // derivative gain

//////////////////////////////
// torque shaping
//////////////////////////////
// below the band the motors get a steeper gain so they come out
// of the dead zone quickly, above it a fixed duty offset is added
`define BAL_LOW_TORQUE_BAND  70   // 5 * P coeff
`define BAL_GAIN_MULT        15   // 1 + min duty / band
`define BAL_MIN_DUTY         980  // duty that keeps the motor stiff

`endif

//--- logic/balance_pkg.sv
// shared signed and unsigned datapath types of the balance controller
`include "balance_defs.svh"

package balance_pkg;

  //////////////////////////////
  // signed datapath types
  //////////////////////////////
  typedef logic signed [`BAL_PTCH_W-1:0]   ptch_t;      // measured pitch
  typedef logic signed [`BAL_ERR_W-1:0]    ptch_err_t;  // saturated pitch error
  typedef logic signed [`BAL_INTEG_W-1:0]  integ_t;     // integrator accumulator
  typedef logic signed [`BAL_TORQUE_W-1:0] torque_t;    // PID terms and torque
  typedef logic signed [`BAL_LD_W-1:0]     ld_diff_t;   // load cell difference

  //////////////////////////////
  // unsigned outputs
  //////////////////////////////
  typedef logic [`BAL_SPD_W-1:0] spd_t;  // motor speed magnitude

endpackage

//--- logic/torque_cmd.sv
// pitch error saturation, P term, PID sum and differential steering
`include "balance_defs.svh"

module torque_cmd import balance_pkg::*; (
  input  ptch_t     ptch,          // measured pitch
  input  ld_diff_t  ld_cell_diff,  // lft load minus rght load
  input  logic      en_steer,      // rider is steering by leaning
  input  torque_t   i_term,        // from integrator, sign extended
  input  torque_t   d_term,        // from derivative, sign extended
  output ptch_err_t ptch_err,      // saturated error, to I and D
  output torque_t   lft_torque,
  output torque_t   rght_torque
);

  localparam int ERR_W = `BAL_ERR_W;
  localparam int PTCH_W = `BAL_PTCH_W;
  localparam ptch_err_t ERR_MAX = {1'b0, {(ERR_W-1){1'b1}}};  // 0x1ff
  localparam ptch_err_t ERR_MIN = {1'b1, {(ERR_W-1){1'b0}}};  // 0x200

  logic    upper_ones;   // bits above error msb all set
  logic    upper_zeros;  // bits above error msb all clear
  torque_t err_ext;      // error widened to torque width
  torque_t p_term;
  torque_t pid_cntrl;
  torque_t ld_ext;       // load difference widened
  torque_t steer;        // load difference / 8

  //////////////////////////////
  // pitch saturation
  //////////////////////////////
  // the value fits in 10 bits when everything from bit 9 up is a copy of the sign
  assign upper_ones  = &ptch[PTCH_W-1:ERR_W-1];
  assign upper_zeros = ~|ptch[PTCH_W-1:ERR_W-1];

  assign ptch_err = (upper_ones || upper_zeros) ? ptch_err_t'(ptch[ERR_W-1:0]) :
                    (ptch[PTCH_W-1] ? ERR_MIN : ERR_MAX);  // clip to the rail

  //////////////////////////////
  // proportional term
  //////////////////////////////
  assign err_ext = torque_t'(ptch_err);  // sign extends
  assign p_term  = err_ext * torque_t'(`BAL_P_COEFF);  // at most 15 bits of magnitude

  //////////////////////////////
  // PID sum and steering
  //////////////////////////////
  assign pid_cntrl = p_term + i_term + d_term;  // wraps at 16 bits

  assign ld_ext = torque_t'(ld_cell_diff);
  assign steer  = ld_ext >>> `BAL_STEER_SHIFT;  // arithmetic, keeps sign

  // leaning load to one side slows that wheel and speeds up the other
  assign lft_torque  = en_steer ? (pid_cntrl - steer) : pid_cntrl;
  assign rght_torque = en_steer ? (pid_cntrl + steer) : pid_cntrl;

endmodule

//--- logic/ptch_integrator.sv
// pitch error integrator with overflow freeze, rider-off clear and I term
`include "balance_defs.svh"

module ptch_integrator import balance_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      vld,        // new inertial reading this cycle
  input  logic      rider_off,  // no weight on the load cells
  input  ptch_err_t ptch_err,
  output torque_t   i_term
);

  localparam int MSB = `BAL_INTEG_W - 1;

  integ_t integ;      // accumulator
  integ_t err_ext;    // error widened to 18 bits
  integ_t nxt_integ;  // candidate sum
  logic   ovfl;       // signed overflow on the candidate

  //////////////////////////////
  // next sum and overflow
  //////////////////////////////
  assign err_ext   = integ_t'(ptch_err);
  assign nxt_integ = integ + err_ext;

  // same sign going in, different sign coming out
  assign ovfl = (integ[MSB] == err_ext[MSB]) && (nxt_integ[MSB] != integ[MSB]);

  //////////////////////////////
  // accumulator
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      integ <= '0;
    end else if (rider_off) begin
      integ <= '0;  // rider stepped off, wind down
    end else if (vld && !ovfl) begin
      integ <= nxt_integ;
    end
    // otherwise hold, this also freezes on overflow
  end

  // upper 12 bits carry the I term
  assign i_term = torque_t'($signed(integ[MSB:`BAL_I_SHIFT]));

endmodule

//--- logic/ptch_derivative.sv
// two-deep pitch error history, saturated difference and D term
`include "balance_defs.svh"

module ptch_derivative import balance_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      vld,       // shift in a new reading
  input  ptch_err_t ptch_err,  // current saturated error
  output torque_t   d_term
);

  localparam int ERR_W  = `BAL_ERR_W;
  localparam int DIFF_W = `BAL_ERR_W + 1;  // full difference of two errors
  localparam int SAT_W  = `BAL_DIFF_W;
  localparam logic signed [SAT_W-1:0] DIFF_MAX = {1'b0, {(SAT_W-1){1'b1}}};  // 0x3f
  localparam logic signed [SAT_W-1:0] DIFF_MIN = {1'b1, {(SAT_W-1){1'b0}}};  // 0x40

  ptch_err_t                 err_q1;    // previous reading
  ptch_err_t                 err_q2;    // reading two strobes back
  logic signed [DIFF_W-1:0]  diff;      // current minus err_q2
  logic signed [SAT_W-1:0]   diff_sat;
  logic                      hi_ones;
  logic                      hi_zeros;

  //////////////////////////////
  // error history
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_q1 <= '0;
      err_q2 <= '0;
    end else if (vld) begin
      err_q1 <= ptch_err;
      err_q2 <= err_q1;  // two readings ago
    end
  end

  //////////////////////////////
  // difference and D term
  //////////////////////////////
  assign diff = {ptch_err[ERR_W-1], ptch_err} - {err_q2[ERR_W-1], err_q2};

  // fits in 7 bits when the bits from 6 up all match the sign
  assign hi_ones  = &diff[DIFF_W-1:SAT_W-1];
  assign hi_zeros = ~|diff[DIFF_W-1:SAT_W-1];

  assign diff_sat = (hi_ones || hi_zeros) ? diff[SAT_W-1:0] :
                    (diff[DIFF_W-1] ? DIFF_MIN : DIFF_MAX);

  assign d_term = torque_t'(diff_sat) * torque_t'(`BAL_D_COEFF);  // at most 13 bits

endmodule

//--- logic/torque_shaper.sv
// torque shaping for one motor: band gain or min duty, magnitude and direction
`include "balance_defs.svh"

module torque_shaper import balance_pkg::*; (
  input  torque_t torque,  // signed torque request
  output spd_t    spd,     // unsigned speed, saturated
  output logic    rev      // 1 runs the motor in reverse
);

  localparam int TQ_W  = `BAL_TORQUE_W;
  localparam int SPD_W = `BAL_SPD_W;

  logic [TQ_W-1:0] abs_torque;   // magnitude of the request
  logic            in_band;      // small torque region
  torque_t         duty_offset;  // torque pushed away from zero
  torque_t         band_gain;    // torque scaled inside the band
  torque_t         shaped;
  logic [TQ_W-1:0] abs_shaped;

  //////////////////////////////
  // band select
  //////////////////////////////
  // two's complement magnitude, 0x8000 stays 0x8000 and reads as large
  assign abs_torque = torque[TQ_W-1] ? -torque : torque;
  assign in_band    = (abs_torque < TQ_W'(`BAL_LOW_TORQUE_BAND));

  //////////////////////////////
  // shaping
  //////////////////////////////
  // outside the band add the minimum duty in the direction of travel
  assign duty_offset = torque[TQ_W-1] ? (torque - torque_t'(`BAL_MIN_DUTY)) :
                                        (torque + torque_t'(`BAL_MIN_DUTY));

  // inside the band a steeper slope meets the offset line at the band edge
  assign band_gain = torque * torque_t'(`BAL_GAIN_MULT);  // truncates to 16 bits

  assign shaped = in_band ? band_gain : duty_offset;

  //////////////////////////////
  // speed and direction
  //////////////////////////////
  assign rev = shaped[TQ_W-1];  // sign of shaped value

  assign abs_shaped = shaped[TQ_W-1] ? -shaped : shaped;

  // anything above 11 bits pins the speed at full scale
  assign spd = (|abs_shaped[TQ_W-1:SPD_W]) ? {SPD_W{1'b1}} : abs_shaped[SPD_W-1:0];

endmodule

//--- logic/balance_cntrl.sv
// balance controller top: PID command, integrator, derivative and two motor shapers
module balance_cntrl import balance_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     vld,           // one-cycle strobe, new inertial reading
  input  ptch_t    ptch,          // measured pitch
  input  ld_diff_t ld_cell_diff,  // lft load minus rght load
  input  logic     rider_off,     // no rider on the platform
  input  logic     en_steer,      // steering by load enabled
  output spd_t     lft_spd,
  output logic     lft_rev,
  output spd_t     rght_spd,
  output logic     rght_rev
);

  ptch_err_t ptch_err;     // saturated pitch error
  torque_t   i_term;       // integral term
  torque_t   d_term;       // derivative term
  torque_t   lft_torque;
  torque_t   rght_torque;

  //////////////////////////////
  // PID command
  //////////////////////////////
  torque_cmd u_torque_cmd (
    .ptch         (ptch),
    .ld_cell_diff (ld_cell_diff),
    .en_steer     (en_steer),
    .i_term       (i_term),
    .d_term       (d_term),
    .ptch_err     (ptch_err),
    .lft_torque   (lft_torque),
    .rght_torque  (rght_torque)
  );

  //////////////////////////////
  // stored state
  //////////////////////////////
  ptch_integrator u_integrator (
    .clk       (clk),
    .rst_n     (rst_n),
    .vld       (vld),
    .rider_off (rider_off),
    .ptch_err  (ptch_err),
    .i_term    (i_term)
  );

  ptch_derivative u_derivative (
    .clk      (clk),
    .rst_n    (rst_n),
    .vld      (vld),
    .ptch_err (ptch_err),
    .d_term   (d_term)
  );

  //////////////////////////////
  // motor shaping
  //////////////////////////////
  torque_shaper u_shape_lft (
    .torque (lft_torque),
    .spd    (lft_spd),
    .rev    (lft_rev)
  );

  torque_shaper u_shape_rght (
    .torque (rght_torque),
    .spd    (rght_spd),
    .rev    (rght_rev)
  );

endmodule

//--- dv/balance_cntrl_properties.sv
// bound integrator checks for rider-off clear, hold without vld and clean state out of reset
`include "balance_defs.svh"

module balance_cntrl_properties import balance_pkg::*; (
  input logic    clk,
  input logic    rst_n,
  input logic    vld,
  input logic    rider_off,
  input integ_t  integ,   // accumulator inside the integrator
  input torque_t i_term
);

  // accumulator reads zero one edge after rider_off
  a_rider_off_clear: assert property (
    @(posedge clk) disable iff (!rst_n) rider_off |=> (integ == '0)
  ) else $error("integrator not cleared one edge after rider_off");

  // accumulator holds when there is neither a reading nor rider_off
  a_hold_without_vld: assert property (
    @(posedge clk) disable iff (!rst_n) (!vld && !rider_off) |=> $stable(integ)
  ) else $error("integrator changed in a cycle without vld");

  // zero I term on the first edge after reset so neither motor starts in reverse
  a_no_rev_out_of_reset: assert property (
    @(posedge clk) $rose(rst_n) |-> ((integ == '0) && !i_term[`BAL_TORQUE_W-1])
  ) else $error("integrator not clear when reset is released");

endmodule

bind ptch_integrator balance_cntrl_properties u_props (
  .clk       (clk),
  .rst_n     (rst_n),
  .vld       (vld),
  .rider_off (rider_off),
  .integ     (integ),
  .i_term    (i_term)
);

//--- include/balance_ref_model.svh
// reference model of the balance controller arithmetic and its mirrored state
`ifndef BALANCE_REF_MODEL_SVH
`define BALANCE_REF_MODEL_SVH

localparam int ERR_LIM   = 1 << (`BAL_ERR_W - 1);      // error range is -512..511
localparam int INTEG_LIM = 1 << (`BAL_INTEG_W - 1);    // accumulator range
localparam int DIFF_LIM  = 1 << (`BAL_DIFF_W - 1);     // derivative range -64..63
localparam int SPD_MAX   = (1 << `BAL_SPD_W) - 1;      // 2047

int m_integ;  // mirrored accumulator
int m_hist1;  // error of the last strobe
int m_hist2;  // error two strobes back

function automatic int clip(input int v, input int lo, input int hi);
  return (v < lo) ? lo : ((v > hi) ? hi : v);
endfunction

// 16 bit two's complement wrap
function automatic int wrap16(input int v);
  int w;
  w = v & 32'hffff;
  return (w > 32767) ? w - 65536 : w;
endfunction

function automatic int sat_err(input int p);
  return clip(p, -ERR_LIM, ERR_LIM - 1);
endfunction

// torque of one motor from present inputs and mirrored state
function automatic int motor_torque(input int p, input int ld, input logic steer,
                                    input logic is_lft);
  int err;
  int pid;
  int st;
  err = sat_err(p);
  pid = err * `BAL_P_COEFF + (m_integ >>> `BAL_I_SHIFT)
        + clip(err - m_hist2, -DIFF_LIM, DIFF_LIM - 1) * `BAL_D_COEFF;
  pid = wrap16(pid);
  st  = steer ? (ld >>> `BAL_STEER_SHIFT) : 0;  // floor divide by 8
  return wrap16(is_lft ? pid - st : pid + st);
endfunction

// band gain or min duty offset, then magnitude and direction
function automatic int shape_speed(input int tq, output logic rev);
  int mag;
  int shaped;
  mag = (tq < 0) ? -tq : tq;
  if (mag >= `BAL_LOW_TORQUE_BAND) begin
    shaped = wrap16((tq < 0) ? tq - `BAL_MIN_DUTY : tq + `BAL_MIN_DUTY);
  end else begin
    shaped = wrap16(tq * `BAL_GAIN_MULT);
  end
  rev = (shaped < 0);
  mag = (shaped < 0) ? -shaped : shaped;
  return (mag > SPD_MAX) ? SPD_MAX : mag;
endfunction

// one clock edge of the stored state
function automatic void advance_state(input int p, input logic v, input logic off);
  int err;
  int sum;
  err = sat_err(p);
  sum = m_integ + err;
  if (off) begin
    m_integ = 0;  // rider off wins over vld
  end else if (v && sum >= -INTEG_LIM && sum < INTEG_LIM) begin
    m_integ = sum;  // out of range sums freeze the accumulator
  end
  if (v) begin
    m_hist2 = m_hist1;
    m_hist1 = err;
  end
endfunction

`endif

//--- dv/balance_cntrl_tb.sv
// testbench with clock, reset, LCG, stimulus table, reference checks, watchdog and summary
`include "balance_defs.svh"

module balance_cntrl_tb import balance_pkg::*; ();

  localparam int CLK_PER = 20;
  localparam int RST_CYC = 16;
  localparam int N_TESTS = 6;

  logic     clk;
  logic     rst_n;
  logic     vld;
  logic     rider_off;
  logic     en_steer;
  ptch_t    ptch;
  ld_diff_t ld_cell_diff;
  spd_t     lft_spd;
  spd_t     rght_spd;
  logic     lft_rev;
  logic     rght_rev;

  //////////////////////////////
  // stimulus table with one row per cycle
  ptch_t       tbl_ptch[$];
  ld_diff_t    tbl_ld[$];
  logic        tbl_steer[$];
  logic        tbl_off[$];
  logic        tbl_vld[$];
  int          tbl_id[$];       // test the row belongs to
  int          n_rows;
  logic [31:0] lcg_state;
  string       test_name[N_TESTS+1];
  int          chk_cnt[N_TESTS+1];
  int          err_cnt[N_TESTS+1];

  `include "balance_ref_model.svh"

  balance_cntrl dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .vld          (vld),
    .ptch         (ptch),
    .ld_cell_diff (ld_cell_diff),
    .rider_off    (rider_off),
    .en_steer     (en_steer),
    .lft_spd      (lft_spd),
    .lft_rev      (lft_rev),
    .rght_spd     (rght_spd),
    .rght_rev     (rght_rev)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #(CLK_PER/2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic add_row(input int p, input int ld, input logic steer, input logic off,
                         input logic v, input int id);
    tbl_ptch.push_back(ptch_t'(p));
    tbl_ld.push_back(ld_diff_t'(ld));
    tbl_steer.push_back(steer);
    tbl_off.push_back(off);
    tbl_vld.push_back(v);
    tbl_id.push_back(id);
  endtask

  //////////////////////////////
  task automatic build_table();
    int          p_only[$] = '{3, -4, 4, 5, -5, -10, 100, 511, -2000, 30000, 0};
    int          d_steps[$] = '{40, 40, -40, -40, 10, 10, 30, 30, 300, -300};
    logic [31:0] r;
    logic [31:0] r2;
    test_name = '{"", "idle after reset", "P only and shaping", "integrator",
                  "derivative", "steering", "random"};
    repeat (2) add_row(0, 0, 1'b0, 1'b0, 1'b0, 1);
    foreach (p_only[k]) add_row(p_only[k], 0, 1'b0, 1'b0, 1'b0, 2);
    repeat (12) add_row(200, 0, 1'b0, 1'b0, 1'b1, 3);  // i_term builds up
    add_row(200, 0, 1'b0, 1'b1, 1'b0, 3);               // rider leaves
    repeat (3) add_row(200, 0, 1'b0, 1'b0, 1'b0, 3);
    foreach (d_steps[k]) add_row(d_steps[k], 0, 1'b0, 1'b0, 1'b1, 4);
    add_row(0, 0, 1'b0, 1'b1, 1'b0, 4);  // park the integrator again
    add_row(10, 800, 1'b1, 1'b0, 1'b0, 5);
    add_row(10, -333, 1'b1, 1'b0, 1'b0, 5);
    add_row(-20, 1000, 1'b1, 1'b0, 1'b0, 5);
    add_row(0, -2048, 1'b1, 1'b0, 1'b0, 5);
    add_row(10, 800, 1'b0, 1'b0, 1'b0, 5);  // steering off gives equal speeds
    // long positive run pushes the accumulator into its overflow freeze
    repeat (320) begin
      r = lcg_next();
      add_row(400 + int'(r[24:16]), int'($signed(r[11:0])), r[31], 1'b0, 1'b1, 6);
    end
    repeat (80) begin
      r  = lcg_next();
      r2 = lcg_next();
      add_row(int'($signed(r[31:16])) >>> r2[3:0], int'($signed(r[11:0])), r2[5],
              (r2[9:6] == 4'd0), r2[4], 6);
    end
  endtask

  task automatic compare_val(input string name, input int id, input logic [31:0] exp,
                             input logic [31:0] act);
    chk_cnt[id]++;
    assert (act === exp) else begin
      $display("Error at time %0t: %s expected %0d, got %0d", $time, name, exp, act);
      err_cnt[id]++;
    end
  endtask

  // expected outputs come from the model state before this row's edge
  task automatic check_row(input int i);
    int   id;
    int   e_lspd;
    int   e_rspd;
    logic e_lrev;
    logic e_rrev;
    id     = tbl_id[i];
    e_lspd = shape_speed(motor_torque(int'(tbl_ptch[i]), int'(tbl_ld[i]), tbl_steer[i], 1'b1),
                         e_lrev);
    e_rspd = shape_speed(motor_torque(int'(tbl_ptch[i]), int'(tbl_ld[i]), tbl_steer[i], 1'b0),
                         e_rrev);
    compare_val("lft_spd", id, 32'(e_lspd), 32'(lft_spd));
    compare_val("lft_rev", id, 32'(e_lrev), 32'(lft_rev));
    compare_val("rght_spd", id, 32'(e_rspd), 32'(rght_spd));
    compare_val("rght_rev", id, 32'(e_rrev), 32'(rght_rev));
  endtask

  //////////////////////////////
  initial begin : main
    int total_chk;
    int total_err;
    lcg_state    = 32'hbc0d;
    rst_n        <= 1'b0;
    vld          <= 1'b0;
    rider_off    <= 1'b0;
    en_steer     <= 1'b0;
    ptch         <= '0;
    ld_cell_diff <= '0;
    m_integ = 0;
    m_hist1 = 0;
    m_hist2 = 0;
    build_table();
    n_rows = tbl_ptch.size();
    repeat (RST_CYC) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk);
      ptch         <= tbl_ptch[i];
      ld_cell_diff <= tbl_ld[i];
      en_steer     <= tbl_steer[i];
      rider_off    <= tbl_off[i];
      vld          <= tbl_vld[i];
      @(negedge clk);  // combinational outputs settled
      check_row(i);
      advance_state(int'(tbl_ptch[i]), tbl_vld[i], tbl_off[i]);
      if (i == n_rows - 1 || tbl_id[i+1] != tbl_id[i]) begin
        $display("test %0d (%s): %0d checks, %0d mismatches", tbl_id[i],
                 test_name[tbl_id[i]], chk_cnt[tbl_id[i]], err_cnt[tbl_id[i]]);
      end
    end
    @(posedge clk);
    vld       <= 1'b0;
    rider_off <= 1'b0;
    total_chk = 0;
    total_err = 0;
    for (int t = 1; t <= N_TESTS; t++) begin
      total_chk += chk_cnt[t];
      total_err += err_cnt[t];
    end
    $display("summary: %0d tests, %0d checks, %0d mismatches", N_TESTS, total_chk, total_err);
    if (total_err == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // run length is reset plus one cycle per row plus margin
  initial begin : watchdog
    wait (n_rows != 0);
    #((n_rows + RST_CYC + 10) * CLK_PER);
    $display("timeout: stimulus did not finish within %0d cycles", n_rows + RST_CYC + 10);
    $display("tests failed");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+include
logic/balance_pkg.sv
logic/torque_cmd.sv
logic/ptch_integrator.sv
logic/ptch_derivative.sv
logic/torque_shaper.sv
logic/balance_cntrl.sv
dv/balance_cntrl_properties.sv
dv/balance_cntrl_tb.sv

//--- Makefile
# Verilator build and run of the balance controller testbench
VERILATOR ?= verilator
TOP       ?= balance_cntrl_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= all tests passed

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard include/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation FAILED, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
